//--- sources.f
bp_pkg.sv
bp_update_if.sv
btb.sv
gshare_predictor.sv
branch_predictor.sv
branch_predictor_sva.sv
tb_branch_predictor.sv

//--- run.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_branch_predictor \
    -f sources.f \
    -o sim_tb_branch_predictor
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb_branch_predictor 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- tb_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int GB           = bp_pkg::GHR_BITS;
    localparam int IB           = bp_pkg::BTB_INDEX_BITS;
    localparam int TAG_LO       = bp_pkg::BTB_INDEX_BITS + 2;

    // Rough cycle cost of each test, doubled for the watchdog
    localparam int RESET_LEN   = RESET_CYCLES + 2;
    localparam int T1_LEN      = 40;
    localparam int T2_LEN      = 30;
    localparam int T3_LEN      = 50;
    localparam int T4_LEN      = 50;
    localparam int T5_LEN      = 20;
    localparam int T6_LEN      = 200 * 6;
    localparam int TOTAL_LEN   = RESET_LEN + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN + T6_LEN;
    localparam int WATCHDOG_NS = 2 * TOTAL_LEN * CLK_PERIOD;

    logic                 clk;
    logic                 reset_i;
    logic [31:0]          pc_i;
    logic                 ghr_clear_i;
    logic                 update_valid_i;
    logic [31:0]          update_pc_i;
    bp_pkg::branch_kind_e update_kind_i;
    logic                 update_taken_i;
    logic [31:0]          update_target_i;
    logic [GB-1:0]        update_pht_index_i;
    logic                 predict_taken_o;
    logic [31:0]          predict_target_o;
    logic [GB-1:0]        pht_index_o;

    // Reference model state
    logic                        m_valid  [bp_pkg::BTB_ENTRIES];
    logic                        m_jump   [bp_pkg::BTB_ENTRIES];
    logic [bp_pkg::BTB_TAG_BITS-1:0] m_tag [bp_pkg::BTB_ENTRIES];
    logic [31:0]                 m_target [bp_pkg::BTB_ENTRIES];
    logic [1:0]                  m_pht    [bp_pkg::PHT_ENTRIES];
    logic [GB-1:0]               m_ghr;

    integer seed = 32'he16d72e1;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    branch_predictor dut (
        .clk                (clk),
        .reset_i            (reset_i),
        .pc_i               (pc_i),
        .ghr_clear_i        (ghr_clear_i),
        .update_valid_i     (update_valid_i),
        .update_pc_i        (update_pc_i),
        .update_kind_i      (update_kind_i),
        .update_taken_i     (update_taken_i),
        .update_target_i    (update_target_i),
        .update_pht_index_i (update_pht_index_i),
        .predict_taken_o    (predict_taken_o),
        .predict_target_o   (predict_target_o),
        .pht_index_o        (pht_index_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("Mismatch %s: %s expected 0x%08h actual 0x%08h", name, what, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < bp_pkg::BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_jump[i]  = 1'b0;
        end
        for (int i = 0; i < bp_pkg::PHT_ENTRIES; i++) begin
            m_pht[i] = bp_pkg::CNT_WEAK_NT;
        end
        m_ghr = '0;
    endtask

    task automatic model_update(input bp_pkg::branch_kind_e kind, input logic [31:0] pc,
                                input logic taken, input logic [31:0] target,
                                input logic [GB-1:0] idx, input logic clear);
        logic [IB-1:0] bidx;
        logic          jump;
        bidx = pc[IB+1:2];
        jump = (kind == bp_pkg::KIND_JAL) || (kind == bp_pkg::KIND_JALR);
        if (kind != bp_pkg::KIND_NONE) begin
            if (jump || (kind == bp_pkg::KIND_BRANCH && taken)) begin
                m_valid[bidx]  = 1'b1;
                m_jump[bidx]   = jump;
                m_tag[bidx]    = pc[31:TAG_LO];
                m_target[bidx] = target;
            end
            if (kind == bp_pkg::KIND_BRANCH) begin
                if (taken && m_pht[idx] != 2'b11) begin
                    m_pht[idx] = m_pht[idx] + 2'd1;
                end else if (!taken && m_pht[idx] != 2'b00) begin
                    m_pht[idx] = m_pht[idx] - 2'd1;
                end
            end
            m_ghr = {m_ghr[GB-2:0], (kind == bp_pkg::KIND_BRANCH) ? taken : 1'b1};
        end
        if (clear) begin
            m_ghr = '0;
        end
    endtask

    // Present a PC, compare all three outputs, hand back the index
    task automatic lookup_check(input string name, input logic [31:0] pc,
                                output logic [GB-1:0] idx);
        logic [IB-1:0] bidx;
        logic          hit;
        logic          exp_taken;
        logic [31:0]   exp_target;
        logic [GB-1:0] exp_index;
        @(negedge clk);
        pc_i = pc;
        #2;
        bidx       = pc[IB+1:2];
        exp_index  = m_ghr ^ pc[GB+1:2];
        hit        = m_valid[bidx] && (m_tag[bidx] == pc[31:TAG_LO]);
        exp_taken  = hit && (m_jump[bidx] || m_pht[exp_index][1]);
        exp_target = exp_taken ? m_target[bidx] : 32'd0;
        check_value(name, "predict_taken", 32'(exp_taken), 32'(predict_taken_o));
        check_value(name, "predict_target", exp_target, predict_target_o);
        check_value(name, "pht_index", 32'(exp_index), 32'(pht_index_o));
        idx = pht_index_o;
    endtask

    task automatic apply_update(input bp_pkg::branch_kind_e kind, input logic [31:0] pc,
                                input logic taken, input logic [31:0] target,
                                input logic [GB-1:0] idx, input logic clear);
        @(negedge clk);
        update_valid_i     = 1'b1;
        update_pc_i        = pc;
        update_kind_i      = kind;
        update_taken_i     = taken;
        update_target_i    = target;
        update_pht_index_i = idx;
        ghr_clear_i        = clear;
        @(negedge clk);
        update_valid_i = 1'b0;
        update_kind_i  = bp_pkg::KIND_NONE;
        ghr_clear_i    = 1'b0;
        model_update(kind, pc, taken, target, idx, clear);
    endtask

    task automatic clear_history();
        @(negedge clk);
        ghr_clear_i = 1'b1;
        @(negedge clk);
        ghr_clear_i = 1'b0;
        m_ghr = '0;
    endtask

    task automatic test_reset_state();
        int            e0;
        logic [31:0]   pc;
        logic [GB-1:0] idx;
        e0 = errors;
        for (int i = 0; i < bp_pkg::BTB_ENTRIES; i++) begin
            pc = ($random(seed) & 32'hffff_ff80) | 32'(i << 2);
            lookup_check("reset_state", pc, idx);
            check_value("reset_state", "pht_index vs pc", 32'(pc[GB+1:2]), 32'(idx));
        end
        finish_test("reset_state", e0);
    endtask

    task automatic test_jump_install();
        int            e0;
        logic [GB-1:0] idx;
        e0 = errors;
        lookup_check("jump_install", 32'h0000_1008, idx);
        apply_update(bp_pkg::KIND_JAL, 32'h0000_1008, 1'b1, 32'h0000_2000, idx, 1'b0);
        lookup_check("jump_install", 32'h0000_1008, idx);
        // Same index, other tag
        lookup_check("jump_install", 32'h0000_1088, idx);
        apply_update(bp_pkg::KIND_JALR, 32'h0000_1008, 1'b1, 32'h0000_3abc, idx, 1'b0);
        lookup_check("jump_install", 32'h0000_1008, idx);
        finish_test("jump_install", e0);
    endtask

    task automatic test_branch_training();
        int            e0;
        logic [GB-1:0] idx;
        logic          outcomes [7];
        e0 = errors;
        outcomes = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
        // History cleared each step so one counter is trained
        for (int i = 0; i < 7; i++) begin
            clear_history();
            lookup_check("branch_training", 32'h0000_4010, idx);
            apply_update(bp_pkg::KIND_BRANCH, 32'h0000_4010, outcomes[i], 32'h0000_4100,
                         idx, 1'b0);
        end
        clear_history();
        lookup_check("branch_training", 32'h0000_4010, idx);
        finish_test("branch_training", e0);
    endtask

    task automatic test_history();
        int                   e0;
        logic [GB-1:0]        idx;
        bp_pkg::branch_kind_e kinds  [6];
        logic                 takens [6];
        e0 = errors;
        kinds  = '{bp_pkg::KIND_BRANCH, bp_pkg::KIND_BRANCH, bp_pkg::KIND_JAL,
                   bp_pkg::KIND_BRANCH, bp_pkg::KIND_JALR, bp_pkg::KIND_BRANCH};
        // Jumps carry a low taken bit, history must still see a one
        takens = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        clear_history();
        for (int i = 0; i < 6; i++) begin
            lookup_check("history", 32'h0000_5030, idx);
            apply_update(kinds[i], 32'h0000_5030, takens[i], 32'h0000_5800, idx, 1'b0);
        end
        lookup_check("history", 32'h0000_5030, idx);
        // Clear in the same cycle as an update
        apply_update(bp_pkg::KIND_BRANCH, 32'h0000_5030, 1'b1, 32'h0000_5800, idx, 1'b1);
        lookup_check("history", 32'h0000_5030, idx);
        check_value("history", "pht_index after clear", 32'h0000_000c, 32'(idx));
        finish_test("history", e0);
    endtask

    task automatic test_no_allocate();
        int            e0;
        logic [GB-1:0] idx;
        logic [GB-1:0] nt_idx;
        logic [GB-1:0] none_idx;
        e0 = errors;
        lookup_check("no_allocate", 32'h0000_6044, nt_idx);
        lookup_check("no_allocate", 32'h0000_7078, none_idx);
        // Both counters taken, so a wrong allocation would predict taken
        for (int i = 0; i < 2; i++) begin
            apply_update(bp_pkg::KIND_BRANCH, 32'h0000_6000, 1'b1, 32'h0000_6800, nt_idx,
                         1'b1);
            apply_update(bp_pkg::KIND_BRANCH, 32'h0000_6000, 1'b1, 32'h0000_6800, none_idx,
                         1'b1);
        end
        apply_update(bp_pkg::KIND_BRANCH, 32'h0000_6044, 1'b0, 32'h0000_6400, nt_idx, 1'b0);
        apply_update(bp_pkg::KIND_NONE, 32'h0000_7078, 1'b1, 32'h0000_7700, none_idx, 1'b0);
        lookup_check("no_allocate", 32'h0000_6044, idx);
        check_value("no_allocate", "predict_taken", 32'd0, 32'(predict_taken_o));
        lookup_check("no_allocate", 32'h0000_7078, idx);
        check_value("no_allocate", "predict_taken", 32'd0, 32'(predict_taken_o));
        finish_test("no_allocate", e0);
    endtask

    task automatic test_random_mix();
        int                   e0;
        logic [GB-1:0]        idx;
        logic [31:0]          pc;
        logic [31:0]          r;
        bp_pkg::branch_kind_e kind;
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            // Few tags per index so hits and conflicts both occur
            pc = $random(seed) & 32'h0000_01fc;
            lookup_check("random_mix", pc, idx);
            r = $random(seed);
            kind = bp_pkg::branch_kind_e'(r[1:0]);
            apply_update(kind, pc, r[2], $random(seed) & 32'hffff_fffc, idx, r[7:4] == 4'd0);
            if (r[11:8] == 4'd0) begin
                clear_history();
            end
        end
        finish_test("random_mix", e0);
    endtask

    initial begin
        reset_i            = 1'b1;
        pc_i               = '0;
        ghr_clear_i        = 1'b0;
        update_valid_i     = 1'b0;
        update_pc_i        = '0;
        update_kind_i      = bp_pkg::KIND_NONE;
        update_taken_i     = 1'b0;
        update_target_i    = '0;
        update_pht_index_i = '0;
        model_reset();
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;

        test_reset_state();
        test_jump_install();
        test_branch_training();
        test_history();
        test_no_allocate();
        test_random_mix();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- branch_predictor_sva.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_sva (
    input logic                        clk,
    input logic                        reset_i,
    input logic [31:0]                 pc_i,
    input logic                        ghr_clear_i,
    input logic                        update_valid_i,
    input logic                        predict_taken_i,
    input logic [31:0]                 predict_target_i,
    input logic [bp_pkg::GHR_BITS-1:0] pht_index_i
);

    // BTB is empty right after reset
    a_not_taken_after_reset: assert property (
        @(posedge clk) reset_i |=> !predict_taken_i
    ) else $error("predict_taken_o high in the cycle after reset");

    a_target_gated: assert property (
        @(posedge clk) disable iff (reset_i)
        !predict_taken_i |-> (predict_target_i == 32'd0)
    ) else $error("predict_target_o nonzero while not taken");

    // History only moves on an update, a clear or a reset
    a_index_stable: assert property (
        @(posedge clk) disable iff (reset_i)
        ($stable(pc_i) && !$past(update_valid_i) && !$past(ghr_clear_i) && !$past(reset_i))
        |-> $stable(pht_index_i)
    ) else $error("pht_index_o changed without a pc change, update or clear");

endmodule

bind branch_predictor branch_predictor_sva u_sva (
    .clk              (clk),
    .reset_i          (reset_i),
    .pc_i             (pc_i),
    .ghr_clear_i      (ghr_clear_i),
    .update_valid_i   (update_valid_i),
    .predict_taken_i  (predict_taken_o),
    .predict_target_i (predict_target_o),
    .pht_index_i      (pht_index_o)
);

`default_nettype wire

//--- branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic [31:0]                   pc_i,
    input  logic                          ghr_clear_i,
    input  logic                          update_valid_i,
    input  logic [31:0]                   update_pc_i,
    input  bp_pkg::branch_kind_e          update_kind_i,
    input  logic                          update_taken_i,
    input  logic [31:0]                   update_target_i,
    input  logic [bp_pkg::GHR_BITS-1:0]   update_pht_index_i,
    output logic                          predict_taken_o,
    output logic [31:0]                   predict_target_o,
    output logic [bp_pkg::GHR_BITS-1:0]   pht_index_o
);

    logic        btb_hit;
    logic        btb_is_jump;
    logic [31:0] btb_target;
    logic        counter_taken;

    bp_update_if upd_if ();

    // Resolved branch from execute
    assign upd_if.valid     = update_valid_i;
    assign upd_if.pc        = update_pc_i;
    assign upd_if.kind      = update_kind_i;
    assign upd_if.taken     = update_taken_i;
    assign upd_if.target    = update_target_i;
    assign upd_if.pht_index = update_pht_index_i;

    btb u_btb (
        .clk         (clk),
        .reset_i     (reset_i),
        .lookup_pc_i (pc_i),
        .upd         (upd_if.sink),
        .hit_o       (btb_hit),
        .is_jump_o   (btb_is_jump),
        .target_o    (btb_target)
    );

    gshare_predictor u_gshare (
        .clk             (clk),
        .reset_i         (reset_i),
        .lookup_pc_i     (pc_i),
        .ghr_clear_i     (ghr_clear_i),
        .upd             (upd_if.sink),
        .pht_index_o     (pht_index_o),
        .counter_taken_o (counter_taken)
    );

    // Jumps are always taken on a hit, branches ask the counter
    assign predict_taken_o  = btb_hit && (btb_is_jump || counter_taken);
    assign predict_target_o = predict_taken_o ? btb_target : 32'd0;

endmodule

`default_nettype wire

//--- gshare_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module gshare_predictor (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic [31:0]                   lookup_pc_i,
    input  logic                          ghr_clear_i,
    bp_update_if.sink                     upd,
    output logic [bp_pkg::GHR_BITS-1:0]   pht_index_o,
    output logic                          counter_taken_o
);

    logic [bp_pkg::GHR_BITS-1:0] ghr_q;
    bp_pkg::counter_e            pht_q [bp_pkg::PHT_ENTRIES];

    bp_pkg::counter_e            rd_cnt;
    logic                        upd_active;
    logic                        upd_branch;
    logic                        resolved_bit;

    // Saturating step in either direction
    function automatic bp_pkg::counter_e step_counter(
        input bp_pkg::counter_e cnt,
        input logic             up
    );
        bp_pkg::counter_e nxt;
        nxt = cnt;
        if (up) begin
            case (cnt)
                bp_pkg::CNT_STRONG_NT: nxt = bp_pkg::CNT_WEAK_NT;
                bp_pkg::CNT_WEAK_NT:   nxt = bp_pkg::CNT_WEAK_T;
                bp_pkg::CNT_WEAK_T:    nxt = bp_pkg::CNT_STRONG_T;
                default:               nxt = bp_pkg::CNT_STRONG_T;
            endcase
        end else begin
            case (cnt)
                bp_pkg::CNT_STRONG_T:  nxt = bp_pkg::CNT_WEAK_T;
                bp_pkg::CNT_WEAK_T:    nxt = bp_pkg::CNT_WEAK_NT;
                bp_pkg::CNT_WEAK_NT:   nxt = bp_pkg::CNT_STRONG_NT;
                default:               nxt = bp_pkg::CNT_STRONG_NT;
            endcase
        end
        return nxt;
    endfunction

    // Gshare hash of history and word address
    assign pht_index_o = ghr_q ^ lookup_pc_i[bp_pkg::GHR_BITS+1:2];

    assign rd_cnt          = pht_q[pht_index_o];
    assign counter_taken_o = rd_cnt[1];

    assign upd_active = upd.valid && (upd.kind != bp_pkg::KIND_NONE);
    assign upd_branch = upd.valid && (upd.kind == bp_pkg::KIND_BRANCH);

    // Jumps always count as taken in the history
    assign resolved_bit = (upd.kind == bp_pkg::KIND_BRANCH) ? upd.taken : 1'b1;

    // History follows resolved outcomes, clear wins
    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (upd_active) begin
            ghr_q <= {ghr_q[bp_pkg::GHR_BITS-2:0], resolved_bit};
        end
    end

    // Counters start weakly not-taken
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < bp_pkg::PHT_ENTRIES; i++) begin
                pht_q[i] <= bp_pkg::CNT_WEAK_NT;
            end
        end else if (upd_branch) begin
            pht_q[upd.pht_index] <= step_counter(pht_q[upd.pht_index], upd.taken);
        end
    end

endmodule

`default_nettype wire

//--- btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb (
    input  logic               clk,
    input  logic               reset_i,
    input  logic [31:0]        lookup_pc_i,
    bp_update_if.sink          upd,
    output logic               hit_o,
    output logic               is_jump_o,
    output logic [31:0]        target_o
);

    logic                            valid_q  [bp_pkg::BTB_ENTRIES];
    logic                            jump_q   [bp_pkg::BTB_ENTRIES];
    logic [bp_pkg::BTB_TAG_BITS-1:0] tag_q    [bp_pkg::BTB_ENTRIES];
    logic [31:0]                     target_q [bp_pkg::BTB_ENTRIES];

    logic [bp_pkg::BTB_INDEX_BITS-1:0] rd_index;
    logic [bp_pkg::BTB_TAG_BITS-1:0]   rd_tag;
    logic [bp_pkg::BTB_INDEX_BITS-1:0] wr_index;
    logic [bp_pkg::BTB_TAG_BITS-1:0]   wr_tag;
    logic                              upd_is_jump;
    logic                              alloc;

    // Lookup side
    assign rd_index = lookup_pc_i[bp_pkg::BTB_INDEX_BITS+1:2];
    assign rd_tag   = lookup_pc_i[31:bp_pkg::BTB_INDEX_BITS+2];

    assign hit_o     = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
    assign is_jump_o = jump_q[rd_index];
    assign target_o  = target_q[rd_index];

    // Write slot comes straight from the resolved PC
    assign wr_index = upd.pc[bp_pkg::BTB_INDEX_BITS+1:2];
    assign wr_tag   = upd.pc[31:bp_pkg::BTB_INDEX_BITS+2];

    assign upd_is_jump = (upd.kind == bp_pkg::KIND_JAL) ||
                         (upd.kind == bp_pkg::KIND_JALR);

    // Not-taken branches never get an entry
    always_comb begin
        alloc = 1'b0;
        if (upd.valid) begin
            if (upd_is_jump) begin
                alloc = 1'b1;
            end else if (upd.kind == bp_pkg::KIND_BRANCH) begin
                alloc = upd.taken;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < bp_pkg::BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
                jump_q[i]  <= 1'b0;
            end
        end else if (alloc) begin
            valid_q[wr_index] <= 1'b1;
            jump_q[wr_index]  <= upd_is_jump;
        end
    end

    // Payload arrays
    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_q[wr_index]    <= wr_tag;
            target_q[wr_index] <= upd.target;
        end
    end

endmodule

`default_nettype wire

//--- bp_update_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bp_update_if;

    // One-cycle strobe from execute
    logic                          valid;
    logic [31:0]                   pc;
    bp_pkg::branch_kind_e          kind;
    logic                          taken;
    logic [31:0]                   target;

    // Index handed out at lookup, carried down the pipe
    logic [bp_pkg::GHR_BITS-1:0]   pht_index;

    modport source (
        output valid,
        output pc,
        output kind,
        output taken,
        output target,
        output pht_index
    );

    modport sink (
        input valid,
        input pc,
        input kind,
        input taken,
        input target,
        input pht_index
    );

endinterface

`default_nettype wire

//--- bp_pkg.sv
`default_nettype none

package bp_pkg;

    // BTB geometry
    localparam int BTB_ENTRIES    = 32;
    localparam int BTB_INDEX_BITS = $clog2(BTB_ENTRIES);

    // PC bits above the index and the two byte-offset bits
    localparam int BTB_TAG_BITS   = 32 - BTB_INDEX_BITS - 2;

    // History length, also the PHT index width
    localparam int GHR_BITS       = 5;
    localparam int PHT_ENTRIES    = 1 << GHR_BITS;

    // Kind of a resolved control instruction
    typedef enum logic [1:0] {
        KIND_NONE   = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_JAL    = 2'd2,
        KIND_JALR   = 2'd3
    } branch_kind_e;

    // 2-bit saturating counter, top bit is the prediction
    typedef enum logic [1:0] {
        CNT_STRONG_NT = 2'b00,
        CNT_WEAK_NT   = 2'b01,
        CNT_WEAK_T    = 2'b10,
        CNT_STRONG_T  = 2'b11
    } counter_e;

endpackage

`default_nettype wire
